// File: gemm_pkg.sv
`default_nettype none

package gemm_pkg;

  // array geometry
  localparam int pe_dim = 4;
  localparam int lane_bits = $clog2(pe_dim);

  // buffer and field widths
  localparam int addr_bits = 8;   // 256 words per buffer
  localparam int dim_bits = 10;
  localparam int off_bits = 9;

  localparam logic [lane_bits-1:0] last_lane = lane_bits'(pe_dim - 1);

  // extra feed cycles past K so the skewed wavefront drains
  localparam logic [dim_bits:0] feed_tail = (dim_bits + 1)'(2 * pe_dim - 1);

  // lane 0 sits in the most significant byte / word
  typedef logic [0:pe_dim-1][7:0] op_word_t;
  typedef logic [0:pe_dim-1][31:0] acc_word_t;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [dim_bits-1:0] dim_t;
  typedef logic signed [off_bits-1:0] off_t;

  // command codes, function_id[9:3]
  localparam logic [6:0] op_set_a = 7'd0;
  localparam logic [6:0] op_set_b = 7'd1;
  localparam logic [6:0] op_start = 7'd2;
  localparam logic [6:0] op_check = 7'd3;
  localparam logic [6:0] op_get_c = 7'd4;

endpackage

`default_nettype wire

// File: tile_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tile_buffer #(
  parameter type word_t = gemm_pkg::op_word_t
) (
  input  logic            clk,
  input  logic            wr_en,
  input  gemm_pkg::addr_t wr_addr,
  input  word_t           wr_data,
  input  gemm_pkg::addr_t rd_addr,
  output word_t           rd_data
);

  word_t mem [2**gemm_pkg::addr_bits];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, old data on a same-address collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: pe.sv
`timescale 1ns/100ps
`default_nettype none

module pe (
  input  logic               clk,
  input  logic               rst,
  input  logic               clear,
  input  logic               en,
  input  logic signed [8:0]  left,
  input  logic signed [7:0]  top,
  output logic signed [8:0]  right,
  output logic signed [7:0]  down,
  output logic signed [31:0] acc
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      right <= '0;
      down  <= '0;
      acc   <= '0;
    end else if (clear) begin
      right <= '0;
      down  <= '0;
      acc   <= '0;
    end else if (en) begin
      acc   <= acc + left * top;
      right <= left;   // pass a to the next column
      down  <= top;
    end
  end

endmodule

`default_nettype wire

// File: systolic_array.sv
`timescale 1ns/100ps
`default_nettype none

module systolic_array (
  input  logic                clk,
  input  logic                rst,
  input  logic                pe_clear,
  input  logic                feed_en,
  input  logic                feed_valid,
  input  gemm_pkg::off_t      offset_q,
  input  gemm_pkg::op_word_t  a_word,
  input  gemm_pkg::op_word_t  b_word,
  output gemm_pkg::acc_word_t rows [gemm_pkg::pe_dim]
);

  localparam int n = gemm_pkg::pe_dim;

  logic signed [8:0] a_in [n];
  logic [7:0]        b_in [n];

  // h[r][0] and v[0][c] are the skewed edge inputs
  wire signed [8:0] h [n][n+1];
  wire signed [7:0] v [n+1][n];
  wire [31:0]       acc_w [n][n];

  // zero past K, offset only on real A data
  always_comb begin
    for (int i = 0; i < n; i++) begin
      if (feed_valid) begin
        a_in[i] = $signed(a_word[i]) + offset_q;
        b_in[i] = b_word[i];
      end else begin
        a_in[i] = '0;
        b_in[i] = '0;
      end
    end
  end

  genvar i, r, c;
  for (i = 0; i < n; i++) begin : g_lane
    if (i == 0) begin : g_direct
      assign h[0][0] = a_in[0];
      assign v[0][0] = b_in[0];
    end else begin : g_skew
      logic signed [8:0] a_q [i];   // lane i waits i cycles
      logic [7:0]        b_q [i];

      always_ff @(posedge clk) begin
        if (pe_clear) begin
          for (int s = 0; s < i; s++) begin
            a_q[s] <= '0;
            b_q[s] <= '0;
          end
        end else if (feed_en) begin
          a_q[0] <= a_in[i];
          b_q[0] <= b_in[i];
          for (int s = 1; s < i; s++) begin
            a_q[s] <= a_q[s-1];
            b_q[s] <= b_q[s-1];
          end
        end
      end

      assign h[i][0] = a_q[i-1];
      assign v[0][i] = b_q[i-1];
    end
  end

  for (r = 0; r < n; r++) begin : g_row
    for (c = 0; c < n; c++) begin : g_col
      pe u_pe (
        .clk   (clk),
        .rst   (rst),
        .clear (pe_clear),
        .en    (feed_en),
        .left  (h[r][c]),
        .top   (v[r][c]),
        .right (h[r][c+1]),
        .down  (v[r+1][c]),
        .acc   (acc_w[r][c])
      );
    end
  end

  always_comb begin
    for (int rr = 0; rr < n; rr++) begin
      for (int cc = 0; cc < n; cc++) begin
        rows[rr][cc] = acc_w[rr][cc];
      end
    end
  end

endmodule

`default_nettype wire

// File: gemm_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module gemm_sequencer (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  gemm_pkg::dim_t      m_size,
  input  gemm_pkg::dim_t      n_size,
  input  gemm_pkg::dim_t      k_size,
  input  gemm_pkg::off_t      offset,
  input  logic                acc_en,
  input  gemm_pkg::addr_t     host_c_addr,
  input  gemm_pkg::acc_word_t c_rd_data,
  input  gemm_pkg::acc_word_t array_rows [gemm_pkg::pe_dim],
  output logic                busy,
  output gemm_pkg::addr_t     a_rd_addr,
  output gemm_pkg::addr_t     b_rd_addr,
  output gemm_pkg::addr_t     c_rd_addr,
  output logic                c_wr_en,
  output gemm_pkg::addr_t     c_wr_addr,
  output gemm_pkg::acc_word_t c_wr_data,
  output logic                pe_clear,
  output logic                feed_en,
  output logic                feed_valid,
  output gemm_pkg::off_t      offset_q
);

  typedef enum logic [1:0] {ph_idle, ph_feed, ph_write, ph_done} phase_t;

  phase_t                            phase_q;
  logic [gemm_pkg::dim_bits:0]       k_q;
  logic [gemm_pkg::dim_bits:0]       k_last;
  gemm_pkg::dim_t                    m_tile_q;
  gemm_pkg::dim_t                    n_tile_q;
  gemm_pkg::dim_t                    m_tiles;
  gemm_pkg::dim_t                    n_tiles;
  logic [gemm_pkg::lane_bits-1:0]    row_q;
  logic                              last_tile;
  gemm_pkg::addr_t                   c_base;

  assign m_tiles   = m_size >> gemm_pkg::lane_bits;   // M, N are multiples of pe_dim
  assign n_tiles   = n_size >> gemm_pkg::lane_bits;
  assign k_last    = {1'b0, k_size} + gemm_pkg::feed_tail;
  assign last_tile = (m_tile_q == m_tiles - 1'b1) && (n_tile_q == n_tiles - 1'b1);
  assign busy      = (phase_q != ph_idle);

  // buffer addressing, all modulo the buffer depth
  assign a_rd_addr = gemm_pkg::addr_t'(m_tile_q * k_size + k_q);
  assign b_rd_addr = gemm_pkg::addr_t'(n_tile_q * k_size + k_q);
  assign c_base    = gemm_pkg::addr_t'(n_tile_q * m_size + (m_tile_q << gemm_pkg::lane_bits));

  always_comb begin
    c_wr_en   = (phase_q == ph_write);
    c_wr_addr = c_base + gemm_pkg::addr_t'(row_q);
    for (int l = 0; l < gemm_pkg::pe_dim; l++) begin
      c_wr_data[l] = array_rows[row_q][l] + (acc_en ? c_rd_data[l] : 32'd0);
    end
    // C is read one row ahead of the write
    case (phase_q)
      ph_feed:  c_rd_addr = c_base;
      ph_write: c_rd_addr = c_base + gemm_pkg::addr_t'(row_q) + 1'b1;
      default:  c_rd_addr = host_c_addr;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase_q    <= ph_idle;
      k_q        <= '0;
      m_tile_q   <= '0;
      n_tile_q   <= '0;
      row_q      <= '0;
      pe_clear   <= 1'b0;
      feed_en    <= 1'b0;
      feed_valid <= 1'b0;
    end else begin
      pe_clear   <= 1'b0;
      feed_en    <= (phase_q == ph_feed);   // lines up with read data
      feed_valid <= (phase_q == ph_feed) && (k_q < {1'b0, k_size});
      case (phase_q)
        ph_idle: begin
          if (start) begin
            phase_q  <= ph_feed;
            k_q      <= '0;
            m_tile_q <= '0;
            n_tile_q <= '0;
            pe_clear <= 1'b1;
          end
        end
        ph_feed: begin
          k_q <= k_q + 1'b1;
          if (k_q == k_last) begin
            phase_q <= ph_write;
            row_q   <= '0;
          end
        end
        ph_write: begin
          row_q <= row_q + 1'b1;
          if (row_q == gemm_pkg::last_lane) begin
            k_q <= '0;
            if (last_tile) begin
              phase_q <= ph_done;
            end else begin
              phase_q  <= ph_feed;
              pe_clear <= 1'b1;
              if (n_tile_q == n_tiles - 1'b1) begin   // n is the inner loop
                n_tile_q <= '0;
                m_tile_q <= m_tile_q + 1'b1;
              end else begin
                n_tile_q <= n_tile_q + 1'b1;
              end
            end
          end
        end
        default: phase_q <= ph_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase_q == ph_idle && start) begin
      offset_q <= offset;
    end
  end

endmodule

`default_nettype wire

// File: cfu_cmd_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module cfu_cmd_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  input  logic [9:0]          cmd_function_id,
  input  logic [31:0]         cmd_inputs_0,
  input  logic [31:0]         cmd_inputs_1,
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output logic [31:0]         rsp_outputs_0,
  input  logic                busy,
  input  gemm_pkg::acc_word_t c_rd_data,
  output logic                a_wr_en,
  output logic                b_wr_en,
  output gemm_pkg::addr_t     a_wr_addr,
  output gemm_pkg::addr_t     b_wr_addr,
  output gemm_pkg::op_word_t  wr_data,
  output logic                start,
  output gemm_pkg::dim_t      m_size,
  output gemm_pkg::dim_t      n_size,
  output gemm_pkg::dim_t      k_size,
  output gemm_pkg::off_t      offset,
  output logic                acc_en,
  output gemm_pkg::addr_t     host_c_addr
);

  typedef enum logic {st_idle, st_resp} state_t;

  state_t                         state_q;
  logic [6:0]                     op;
  logic                           take;
  logic                           do_set_a;
  logic                           do_set_b;
  logic                           do_start;
  logic                           do_get_c;
  logic [gemm_pkg::lane_bits-1:0] lane_q;
  logic [31:0]                    rsp_next;

  assign rsp_valid = (state_q == st_resp);
  assign cmd_ready = !rsp_valid;
  assign take      = cmd_valid && cmd_ready;
  assign op        = cmd_function_id[9:3];

  // only check_GEMM acts while the array runs
  assign do_set_a = take && !busy && (op == gemm_pkg::op_set_a);
  assign do_set_b = take && !busy && (op == gemm_pkg::op_set_b);
  assign do_start = take && !busy && (op == gemm_pkg::op_start);
  assign do_get_c = take && !busy && (op == gemm_pkg::op_get_c);

  always_comb begin
    rsp_next = '0;
    case (op)
      gemm_pkg::op_check: rsp_next = {31'd0, busy};
      gemm_pkg::op_get_c: begin
        if (!busy) begin
          rsp_next = c_rd_data[lane_q];
        end
      end
      default: rsp_next = '0;   // writes and unknown codes
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q     <= st_idle;
      a_wr_en     <= 1'b0;
      b_wr_en     <= 1'b0;
      a_wr_addr   <= '0;
      b_wr_addr   <= '0;
      start       <= 1'b0;
      host_c_addr <= '0;
      lane_q      <= '0;
    end else begin
      a_wr_en <= do_set_a;
      b_wr_en <= do_set_b;
      start   <= do_start;
      if (a_wr_en) a_wr_addr <= a_wr_addr + 1'b1;   // bump after the write lands
      if (b_wr_en) b_wr_addr <= b_wr_addr + 1'b1;

      case (state_q)
        st_idle: if (take) state_q <= st_resp;
        default: if (rsp_ready) state_q <= st_idle;
      endcase

      if (do_start) begin
        a_wr_addr   <= '0;
        b_wr_addr   <= '0;
        host_c_addr <= '0;
        lane_q      <= '0;
      end

      if (do_get_c) begin
        if (lane_q == gemm_pkg::last_lane) begin
          lane_q      <= '0;
          host_c_addr <= host_c_addr + 1'b1;   // next row read during the response
        end else begin
          lane_q <= lane_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) rsp_outputs_0 <= rsp_next;
    if (do_set_a || do_set_b) wr_data <= cmd_inputs_0;
    if (do_start) begin
      acc_en <= cmd_inputs_0[30];
      m_size <= cmd_inputs_0[29:20];
      n_size <= cmd_inputs_0[19:10];
      k_size <= cmd_inputs_0[9:0];
      offset <= cmd_inputs_1[gemm_pkg::off_bits-1:0];
    end
  end

endmodule

`default_nettype wire

// File: cfu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cfu_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [9:0]  cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  output logic        rsp_valid,
  input  logic        rsp_ready,
  output logic [31:0] rsp_outputs_0
);

  logic                busy;
  logic                start;
  logic                acc_en;
  gemm_pkg::dim_t      m_size;
  gemm_pkg::dim_t      n_size;
  gemm_pkg::dim_t      k_size;
  gemm_pkg::off_t      offset;
  gemm_pkg::off_t      offset_q;

  logic                a_wr_en;
  logic                b_wr_en;
  gemm_pkg::addr_t     a_wr_addr;
  gemm_pkg::addr_t     b_wr_addr;
  gemm_pkg::op_word_t  wr_data;
  gemm_pkg::addr_t     a_rd_addr;
  gemm_pkg::addr_t     b_rd_addr;
  gemm_pkg::op_word_t  a_rd_data;
  gemm_pkg::op_word_t  b_rd_data;

  logic                c_wr_en;
  gemm_pkg::addr_t     c_wr_addr;
  gemm_pkg::acc_word_t c_wr_data;
  gemm_pkg::addr_t     c_rd_addr;
  gemm_pkg::acc_word_t c_rd_data;
  gemm_pkg::addr_t     host_c_addr;

  logic                pe_clear;
  logic                feed_en;
  logic                feed_valid;
  gemm_pkg::acc_word_t array_rows [gemm_pkg::pe_dim];

  cfu_cmd_ctrl u_cmd_ctrl (
    .clk, .rst,
    .cmd_valid, .cmd_ready, .cmd_function_id, .cmd_inputs_0, .cmd_inputs_1,
    .rsp_valid, .rsp_ready, .rsp_outputs_0,
    .busy, .c_rd_data,
    .a_wr_en, .b_wr_en, .a_wr_addr, .b_wr_addr, .wr_data,
    .start, .m_size, .n_size, .k_size, .offset, .acc_en, .host_c_addr
  );

  gemm_sequencer u_sequencer (
    .clk, .rst,
    .start, .m_size, .n_size, .k_size, .offset, .acc_en, .host_c_addr,
    .c_rd_data, .array_rows,
    .busy, .a_rd_addr, .b_rd_addr, .c_rd_addr,
    .c_wr_en, .c_wr_addr, .c_wr_data,
    .pe_clear, .feed_en, .feed_valid, .offset_q
  );

  systolic_array u_array (
    .clk, .rst, .pe_clear, .feed_en, .feed_valid, .offset_q,
    .a_word (a_rd_data),
    .b_word (b_rd_data),
    .rows   (array_rows)
  );

  tile_buffer #(.word_t(gemm_pkg::op_word_t)) buf_a (
    .clk, .wr_en(a_wr_en), .wr_addr(a_wr_addr), .wr_data(wr_data),
    .rd_addr(a_rd_addr), .rd_data(a_rd_data)
  );

  tile_buffer #(.word_t(gemm_pkg::op_word_t)) buf_b (
    .clk, .wr_en(b_wr_en), .wr_addr(b_wr_addr), .wr_data(wr_data),
    .rd_addr(b_rd_addr), .rd_data(b_rd_data)
  );

  tile_buffer #(.word_t(gemm_pkg::acc_word_t)) buf_c (
    .clk, .wr_en(c_wr_en), .wr_addr(c_wr_addr), .wr_data(c_wr_data),
    .rd_addr(c_rd_addr), .rd_data(c_rd_data)
  );

endmodule

`default_nettype wire

// File: tb_gemm_model.svh
`ifndef tb_gemm_model_svh
`define tb_gemm_model_svh

  // row major, sized for the largest test
  int a_mat [8][8];   // M x K
  int b_mat [8][8];   // K x N
  int c_mat [8][8];   // M x N, old C when accumulating

  function automatic int rand_int8();
    return int'($urandom_range(0, 255)) - 128;
  endfunction

  function automatic void fill_operands(input int m, input int n, input int k);
    for (int i = 0; i < m; i++) begin
      for (int kk = 0; kk < k; kk++) begin
        a_mat[i][kk] = rand_int8();
      end
    end
    for (int kk = 0; kk < k; kk++) begin
      for (int j = 0; j < n; j++) begin
        b_mat[kk][j] = rand_int8();
      end
    end
  endfunction

  // one element of C, sum over k of (a + off) * b
  function automatic int expected_c_elem(input int i, input int j, input int k, input int off,
                                         input bit acc);
    int sum;
    sum = acc ? c_mat[i][j] : 0;
    for (int kk = 0; kk < k; kk++) begin
      sum += (a_mat[i][kk] + off) * b_mat[kk][j];
    end
    return sum;
  endfunction

`endif

// File: tb_cfu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cfu;

  logic        clk = 1'b0;
  logic        rst;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [9:0]  cmd_function_id;
  logic [31:0] cmd_inputs_0;
  logic [31:0] cmd_inputs_1;
  logic        rsp_valid;
  logic        rsp_ready;
  logic [31:0] rsp_outputs_0;

  logic [6:0]  cur_op;
  logic [31:0] exp_q [$];   // expected get_matrixC words in read order
  logic [31:0] held_data;
  logic        held;
  int          errors;
  int          tests_run;
  int          tests_failed;

  `include "tb_gemm_model.svh"

  cfu_top uut (
    .clk, .rst,
    .cmd_valid, .cmd_ready, .cmd_function_id, .cmd_inputs_0, .cmd_inputs_1,
    .rsp_valid, .rsp_ready, .rsp_outputs_0
  );

  always #50 clk = ~clk;

  // compares C words on accept, and checks a stalled response stays put
  always @(posedge clk) begin
    if (rst) begin
      held = 1'b0;
    end else begin
      if (held) begin
        assert (rsp_valid && !cmd_ready) else begin
          errors++;
          $display("rsp_valid fell or cmd_ready rose while rsp_ready was low at %0t", $time);
        end
        assert (rsp_outputs_0 === held_data) else begin
          errors++;
          $display("Mismatch at %0t: rsp_outputs_0 got %h expected %h (held)",
                   $time, rsp_outputs_0, held_data);
        end
      end
      held      = rsp_valid && !rsp_ready;
      held_data = rsp_outputs_0;
      if (rsp_valid && rsp_ready && cur_op == gemm_pkg::op_get_c) begin
        assert (exp_q.size() > 0) else begin
          errors++;
          $display("get_matrixC returned more words than expected at %0t", $time);
        end
        if (exp_q.size() > 0) begin
          assert (rsp_outputs_0 === exp_q[0]) else begin
            errors++;
            $display("Mismatch at %0t: rsp_outputs_0 got %h expected %h",
                     $time, rsp_outputs_0, exp_q[0]);
          end
          void'(exp_q.pop_front());
        end
      end
    end
  end

  function automatic void flag_timeout(input string why);
    errors++;
    $display("%s at %0t", why, $time);
  endfunction

  function automatic void report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err_before);
    end
  endfunction

  // A word holds column k of a row tile with lane 0 in the top byte
  function automatic logic [31:0] pack_a_word(input int mt, input int k);
    logic [31:0] w;
    w = '0;
    for (int l = 0; l < gemm_pkg::pe_dim; l++) begin
      w = {w[23:0], 8'(a_mat[mt * gemm_pkg::pe_dim + l][k])};
    end
    return w;
  endfunction

  function automatic logic [31:0] pack_b_word(input int nt, input int k);
    logic [31:0] w;
    w = '0;
    for (int l = 0; l < gemm_pkg::pe_dim; l++) begin
      w = {w[23:0], 8'(b_mat[k][nt * gemm_pkg::pe_dim + l])};
    end
    return w;
  endfunction

  // one command and its response; stall keeps rsp_ready low a few cycles
  task automatic send_cmd(input logic [6:0] op, input logic [31:0] in0, input logic [31:0] in1,
                          input bit stall, output logic [31:0] result);
    int tries;
    @(negedge clk);
    tries = 0;
    while (!cmd_ready && tries < 20) begin
      @(negedge clk);
      tries++;
    end
    assert (cmd_ready) else begin
      flag_timeout("cmd_ready stayed low");
    end
    cur_op          = op;
    cmd_valid       = 1'b1;
    cmd_function_id = {op, 3'b000};
    cmd_inputs_0    = in0;
    cmd_inputs_1    = in1;
    rsp_ready       = !stall;
    @(negedge clk);
    cmd_valid = 1'b0;
    tries = 0;
    while (!rsp_valid && tries < 20) begin
      @(negedge clk);
      tries++;
    end
    assert (rsp_valid) else begin
      flag_timeout("no response to a command");
    end
    if (stall) begin
      repeat ($urandom_range(1, 5)) @(negedge clk);
      rsp_ready = 1'b1;
    end
    result = rsp_outputs_0;
    @(posedge clk);   // accepted here
  endtask

  task automatic load_operands(input int m, input int n, input int k);
    logic [31:0] unused;
    for (int mt = 0; mt < m / gemm_pkg::pe_dim; mt++) begin
      for (int kk = 0; kk < k; kk++) begin
        send_cmd(gemm_pkg::op_set_a, pack_a_word(mt, kk), 32'd0, 1'b0, unused);
      end
    end
    for (int nt = 0; nt < n / gemm_pkg::pe_dim; nt++) begin
      for (int kk = 0; kk < k; kk++) begin
        send_cmd(gemm_pkg::op_set_b, pack_b_word(nt, kk), 32'd0, 1'b0, unused);
      end
    end
  endtask

  task automatic wait_idle();
    logic [31:0] status;
    int polls;
    polls  = 0;
    status = 32'd1;
    while (status != 0 && polls < 100) begin
      send_cmd(gemm_pkg::op_check, 32'd0, 32'd0, 1'b0, status);
      polls++;
    end
    assert (status == 0) else begin
      flag_timeout("GEMM still busy after 100 polls");
    end
  endtask

  task automatic run_product(input int m, input int n, input int k, input int off,
                             input bit acc, input bit stall);
    logic [31:0] word;
    logic [31:0] cmd0;
    load_operands(m, n, k);
    cmd0 = {1'b0, acc, 10'(m), 10'(n), 10'(k)};
    send_cmd(gemm_pkg::op_start, cmd0, 32'(off), 1'b0, word);
    wait_idle();
    for (int i = 0; i < m; i++) begin
      for (int j = 0; j < n; j++) begin
        c_mat[i][j] = expected_c_elem(i, j, k, off, acc);
      end
    end
    // C rows go column tile by column tile
    for (int addr = 0; addr < m * n / gemm_pkg::pe_dim; addr++) begin
      for (int l = 0; l < gemm_pkg::pe_dim; l++) begin
        exp_q.push_back(c_mat[addr % m][(addr / m) * gemm_pkg::pe_dim + l]);
      end
    end
    repeat (m * n) send_cmd(gemm_pkg::op_get_c, 32'd0, 32'd0, stall, word);
    @(negedge clk);
    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d C words were never returned", exp_q.size());
      exp_q.delete();
    end
  endtask

  initial begin : run_tests
    logic [31:0] status;
    int err_before;
    int off;
    void'($urandom(32'haa1));
    rst             = 1'b1;
    cmd_valid       = 1'b0;
    cmd_function_id = '0;
    cmd_inputs_0    = '0;
    cmd_inputs_1    = '0;
    rsp_ready       = 1'b1;
    cur_op          = gemm_pkg::op_check;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    err_before = errors;
    assert (!rsp_valid && cmd_ready) else begin
      errors++;
      $display("handshake not idle after reset");
    end
    send_cmd(gemm_pkg::op_check, 32'd0, 32'd0, 1'b0, status);
    assert (status == 32'd0) else begin
      errors++;
      $display("Mismatch at %0t: check_GEMM got %h expected 0", $time, status);
    end
    report_test("reset and idle", err_before);

    err_before = errors;
    fill_operands(4, 4, 4);
    run_product(4, 4, 4, 0, 1'b0, 1'b0);
    report_test("4x4x4 zero offset", err_before);

    err_before = errors;
    off = int'($urandom_range(0, 256)) - 128;   // keeps a + off inside 9 bits
    fill_operands(8, 8, 6);
    run_product(8, 8, 6, off, 1'b0, 1'b0);
    report_test("8x8 k=6 random offset", err_before);

    err_before = errors;
    off = int'($urandom_range(0, 256)) - 128;
    fill_operands(8, 8, 6);
    run_product(8, 8, 6, off, 1'b1, 1'b0);
    report_test("accumulate into C", err_before);

    err_before = errors;
    off = int'($urandom_range(0, 256)) - 128;
    fill_operands(4, 8, 5);
    run_product(4, 8, 5, off, 1'b0, 1'b1);
    report_test("readback with back-pressure", err_before);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
gemm_pkg.sv
tile_buffer.sv
pe.sv
systolic_array.sv
gemm_sequencer.sv
cfu_cmd_ctrl.sv
cfu_top.sv
tb_cfu.sv

// File: Bender.yml
package:
  name: cfu_gemm

sources:
  - files:
      - gemm_pkg.sv
      - tile_buffer.sv
      - pe.sv
      - systolic_array.sv
      - gemm_sequencer.sv
      - cfu_cmd_ctrl.sv
      - cfu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_cfu.sv
